/* moxie_decode_top.f */
+incdir+.
moxie_pkg.sv
decode_if.sv
microcode_rom.sv
instr_decoder.sv
reg_file.sv
operand_fetch.sv
moxie_decode_top.sv
tb_moxie_decode_top.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

SIM      = verilator
TOP      = tb_moxie_decode_top
FILELIST = moxie_decode_top.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(filter-out +%,$(shell cat $(FILELIST)))
HDRS     = $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_moxie_decode_top.sv */
/* directed testbench for the moxie decode stage
   drives instructions on the falling edge and checks decoded fields one cycle later */

`timescale 1ns/100ps

`include "moxie_consts.svh"

module tb_moxie_decode_top;

  localparam int NUM_TESTS   = 6;
  localparam int CLK_PERIOD  = 20;
  localparam int WATCHDOG_NS = 400 * NUM_TESTS * CLK_PERIOD;

  // control bits expected for each instruction category
  localparam moxie_pkg::pcb_t PCB_NONE  = 6'b000000;
  localparam moxie_pkg::pcb_t PCB_WA    = 6'b100000;
  localparam moxie_pkg::pcb_t PCB_LOAD  = 6'b101000;
  localparam moxie_pkg::pcb_t PCB_STORE = 6'b000100;
  localparam moxie_pkg::pcb_t PCB_PUSH  = 6'b010100;
  localparam moxie_pkg::pcb_t PCB_POP   = 6'b111000;
  localparam moxie_pkg::pcb_t PCB_FLOW  = 6'b000010;
  localparam moxie_pkg::pcb_t PCB_SYS   = 6'b000001;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       stall_i;
  logic                       flush_i;
  logic                       valid_i;
  logic [`MOXIE_INSN_W-1:0]   opcode_i;
  moxie_pkg::word_t           operand_i;
  moxie_pkg::word_t           pc_i;
  logic                       wb_a_en_i;
  moxie_pkg::reg_idx_t        wb_a_idx_i;
  moxie_pkg::word_t           wb_a_data_i;
  logic                       wb_b_en_i;
  moxie_pkg::reg_idx_t        wb_b_idx_i;
  moxie_pkg::word_t           wb_b_data_i;
  moxie_pkg::word_t           ex_result_a_i;
  moxie_pkg::word_t           ex_result_b_i;
  moxie_pkg::op_e             op_o;
  moxie_pkg::pcb_t            pcb_o;
  moxie_pkg::reg_idx_t        wr_idx_a_o;
  moxie_pkg::reg_idx_t        wr_idx_b_o;
  moxie_pkg::word_t           operand_o;
  logic [`MOXIE_OFFSET_W-1:0] offset_o;
  moxie_pkg::word_t           pc_o;
  moxie_pkg::word_t           src_a_o;
  moxie_pkg::word_t           src_b_o;

  int err_count;
  int check_count;
  int tests_run;
  int tests_failed;
  int seed_ret;

  moxie_decode_top moxie_decode_top_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .valid_i       (valid_i),
    .opcode_i      (opcode_i),
    .operand_i     (operand_i),
    .pc_i          (pc_i),
    .wb_a_en_i     (wb_a_en_i),
    .wb_a_idx_i    (wb_a_idx_i),
    .wb_a_data_i   (wb_a_data_i),
    .wb_b_en_i     (wb_b_en_i),
    .wb_b_idx_i    (wb_b_idx_i),
    .wb_b_data_i   (wb_b_data_i),
    .ex_result_a_i (ex_result_a_i),
    .ex_result_b_i (ex_result_b_i),
    .op_o          (op_o),
    .pcb_o         (pcb_o),
    .wr_idx_a_o    (wr_idx_a_o),
    .wr_idx_b_o    (wr_idx_b_o),
    .operand_o     (operand_o),
    .offset_o      (offset_o),
    .pc_o          (pc_o),
    .src_a_o       (src_a_o),
    .src_b_o       (src_b_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // ends a run that stops making progress
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  task automatic check_op(input moxie_pkg::op_e got, input moxie_pkg::op_e exp,
                          input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("CHECK FAILED at %0t: %s op %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_pcb(input moxie_pkg::pcb_t got, input moxie_pkg::pcb_t exp,
                           input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("CHECK FAILED at %0t: %s pcb %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input moxie_pkg::word_t got, input moxie_pkg::word_t exp,
                            input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("CHECK FAILED at %0t: %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input moxie_pkg::reg_idx_t got, input moxie_pkg::reg_idx_t exp,
                           input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("CHECK FAILED at %0t: %s r%0d, expected r%0d", $time, what, got, exp);
    end
  endtask

  // starts on a falling edge and returns on the next one after capture
  task automatic issue(input logic [`MOXIE_INSN_W-1:0] opc, input moxie_pkg::word_t opnd);
    opcode_i  = opc;
    operand_i = opnd;
    pc_i      = pc_i + 32'd2;
    valid_i   = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic expect_decode(input logic [`MOXIE_INSN_W-1:0] opc, input moxie_pkg::word_t opnd,
                               input moxie_pkg::op_e exp_op, input moxie_pkg::pcb_t exp_pcb,
                               input string what);
    issue(opc, opnd);
    check_op(op_o, exp_op, what);
    check_pcb(pcb_o, exp_pcb, what);
  endtask

  function automatic moxie_pkg::word_t offset_word();
    return {{(`MOXIE_XLEN-`MOXIE_OFFSET_W){1'b0}}, offset_o};
  endfunction

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic decode_table_test();
    int errs;
    moxie_pkg::word_t v;
    errs = err_count;
    v = $urandom;
    expect_decode(16'h0110, v, moxie_pkg::OP_LDI_L, PCB_WA, "ldi.l");
    check_word(operand_o, v, "ldi.l operand");
    expect_decode(16'h0235, $urandom, moxie_pkg::OP_MOV, PCB_WA, "mov");
    check_word(operand_o, v, "mov operand held");
    v = $urandom;
    expect_decode(16'h0820, v, moxie_pkg::OP_LDA_L, PCB_LOAD, "lda.l");
    check_word(operand_o, v, "lda.l operand");
    v = $urandom;
    expect_decode(16'h0d12, v, moxie_pkg::OP_STO_L, PCB_STORE, "sto.l");
    check_word(operand_o, {16'h0000, v[31:16]}, "sto.l operand");
    expect_decode(16'h0612, $urandom, moxie_pkg::OP_PUSH, PCB_PUSH, "push");
    check_word(operand_o, {16'h0000, v[31:16]}, "push operand held");
    expect_decode(16'h0712, $urandom, moxie_pkg::OP_POP, PCB_POP, "pop");
    expect_decode(16'h0400, $urandom, moxie_pkg::OP_RET, PCB_FLOW, "ret");
    expect_decode(16'h3000, $urandom, moxie_pkg::OP_SWI, PCB_SYS, "swi");
    expect_decode(16'h0e12, $urandom, moxie_pkg::OP_CMP, PCB_NONE, "cmp");
    expect_decode(16'h837f, $urandom, moxie_pkg::OP_INC, PCB_WA, "inc");
    check_word(operand_o, 32'h0000_007f, "inc operand");
    expect_decode(16'h92c4, $urandom, moxie_pkg::OP_DEC, PCB_WA, "dec");
    check_word(operand_o, 32'h0000_00c4, "dec operand");
    expect_decode(16'hc6a5, $urandom, moxie_pkg::OP_BNE, PCB_NONE, "bne");
    check_word(offset_word(), 32'h0000_02a5, "bne offset");
    expect_decode(16'he7ff, $urandom, moxie_pkg::OP_BLEU, PCB_NONE, "bleu");
    check_word(offset_word(), 32'h0000_03ff, "bleu offset");
    expect_decode(16'h1400, $urandom, moxie_pkg::OP_BAD, PCB_NONE, "unassigned form 1");
    expect_decode(16'hf000, $urandom, moxie_pkg::OP_BAD, PCB_NONE, "unassigned form 3");
    report_test("decode table", errs);
  endtask

  task automatic reg_index_test();
    int errs;
    errs = err_count;
    expect_decode(16'h02a7, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov r10, r7");
    check_idx(wr_idx_a_o, 4'ha, "form 1 index a");
    check_idx(wr_idx_b_o, 4'h7, "form 1 index b");
    expect_decode(16'h8c15, 32'h0, moxie_pkg::OP_INC, PCB_WA, "inc r12");
    check_idx(wr_idx_a_o, 4'hc, "form 2 index a");
    check_idx(wr_idx_b_o, 4'h5, "form 2 index b");
    expect_decode(16'ha642, 32'h0, moxie_pkg::OP_GSR, PCB_NONE, "gsr r6");
    check_idx(wr_idx_a_o, 4'h6, "gsr index a");
    check_idx(wr_idx_b_o, 4'h2, "gsr index b");
    report_test("register indices", errs);
  endtask

  task automatic bubble_test();
    int errs;
    errs = err_count;
    // pop stays on the inputs through reset, so only the reset can clear its pcb
    expect_decode(16'h0712, 32'h0, moxie_pkg::OP_POP, PCB_POP, "pop before reset");
    rst_n_i = 1'b0;
    repeat (2) @(negedge clk_i);
    check_op(op_o, moxie_pkg::OP_NOP, "op in reset");
    check_pcb(pcb_o, PCB_NONE, "pcb in reset");
    rst_n_i = 1'b1;
    expect_decode(16'h0231, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov r3, r1");
    opcode_i = 16'h0645;
    valid_i  = 1'b0;
    @(negedge clk_i);
    check_op(op_o, moxie_pkg::OP_NOP, "valid low");
    check_pcb(pcb_o, PCB_NONE, "valid low");
    check_idx(wr_idx_a_o, 4'h3, "index held while invalid");
    valid_i = 1'b1;
    flush_i = 1'b1;
    @(negedge clk_i);
    check_op(op_o, moxie_pkg::OP_NOP, "flush");
    check_pcb(pcb_o, PCB_NONE, "flush");
    flush_i = 1'b0;
    @(negedge clk_i);
    check_op(op_o, moxie_pkg::OP_PUSH, "push after flush");
    check_pcb(pcb_o, PCB_PUSH, "push after flush");
    report_test("invalid and flush", errs);
  endtask

  task automatic stall_test();
    int errs;
    moxie_pkg::word_t v;
    moxie_pkg::word_t r4;
    moxie_pkg::word_t r0;
    moxie_pkg::word_t pc_held;
    errs = err_count;
    v  = $urandom;
    r4 = $urandom;
    r0 = $urandom;
    // distinct register contents make a moving read visible
    write_back(4'h4, r4, 4'h0, r0);
    expect_decode(16'h0140, v, moxie_pkg::OP_LDI_L, PCB_WA, "ldi.l before stall");
    check_word(pc_o, pc_i, "pc before stall");
    check_word(src_a_o, r4, "src a before stall");
    check_word(src_b_o, r0, "src b before stall");
    pc_held = pc_i;
    stall_i = 1'b1;
    repeat (5)
    begin
      opcode_i  = 16'($urandom);
      operand_i = $urandom;
      pc_i      = $urandom;
      @(negedge clk_i);
      check_op(op_o, moxie_pkg::OP_LDI_L, "op under stall");
      check_pcb(pcb_o, PCB_WA, "pcb under stall");
      check_idx(wr_idx_a_o, 4'h4, "index a under stall");
      check_idx(wr_idx_b_o, 4'h0, "index b under stall");
      check_word(operand_o, v, "operand under stall");
      check_word(pc_o, pc_held, "pc under stall");
      check_word(offset_word(), 32'h0000_0140, "offset under stall");
      check_word(src_a_o, r4, "src a under stall");
      check_word(src_b_o, r0, "src b under stall");
    end
    stall_i = 1'b0;
    expect_decode(16'h0253, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov after stall");
    check_word(pc_o, pc_i, "pc after stall");
    report_test("stall", errs);
  endtask

  task automatic write_back(input moxie_pkg::reg_idx_t idx_a, input moxie_pkg::word_t data_a,
                            input moxie_pkg::reg_idx_t idx_b, input moxie_pkg::word_t data_b);
    wb_a_en_i   = 1'b1;
    wb_a_idx_i  = idx_a;
    wb_a_data_i = data_a;
    wb_b_en_i   = 1'b1;
    wb_b_idx_i  = idx_b;
    wb_b_data_i = data_b;
    // cmp writes nothing and raises no forwarding flag for the next read
    expect_decode(16'h0e00, 32'h0, moxie_pkg::OP_CMP, PCB_NONE, "cmp during writeback");
    wb_a_en_i = 1'b0;
    wb_b_en_i = 1'b0;
  endtask

  task automatic reg_file_test();
    int errs;
    moxie_pkg::word_t r_a;
    moxie_pkg::word_t r_b;
    moxie_pkg::word_t r_c;
    errs = err_count;
    r_a = $urandom;
    r_b = $urandom;
    ex_result_a_i = ~r_a;
    ex_result_b_i = ~r_b;
    write_back(4'h3, r_a, 4'h9, r_b);
    expect_decode(16'h0239, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov r3, r9");
    check_word(src_a_o, r_a, "r3 read back");
    check_word(src_b_o, r_b, "r9 read back");
    expect_decode(16'h0e00, 32'h0, moxie_pkg::OP_CMP, PCB_NONE, "cmp spacer");
    // write r3 on the same edge that reads it
    wb_a_en_i   = 1'b1;
    wb_a_idx_i  = 4'h3;
    wb_a_data_i = $urandom;
    expect_decode(16'h0239, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov during write");
    wb_a_en_i = 1'b0;
    check_word(src_a_o, r_a, "old r3 on same-edge read");
    r_b = $urandom;
    r_c = $urandom;
    write_back(4'h5, r_b, 4'h5, r_c);
    expect_decode(16'h0255, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov r5, r5");
    check_word(src_a_o, r_c, "dual write keeps port b");
    check_word(src_b_o, r_c, "dual write keeps port b");
    report_test("register file", errs);
  endtask

  task automatic forwarding_test();
    int errs;
    moxie_pkg::word_t rv4;
    moxie_pkg::word_t rv7;
    errs = err_count;
    rv4 = $urandom;
    rv7 = $urandom;
    write_back(4'h4, rv4, 4'h7, rv7);
    ex_result_a_i = ~rv4;
    ex_result_b_i = $urandom;
    expect_decode(16'h0542, 32'h0, moxie_pkg::OP_ADD_L, PCB_WA, "add.l r4, r2");
    expect_decode(16'h0247, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov after add.l");
    check_word(src_a_o, ex_result_a_i, "src a forwarded from execute");
    check_word(src_b_o, rv7, "src b from registers");
    expect_decode(16'h0942, $urandom, moxie_pkg::OP_STA_L, PCB_STORE, "sta.l r4");
    expect_decode(16'h0247, 32'h0, moxie_pkg::OP_MOV, PCB_WA, "mov after sta.l");
    check_word(src_a_o, rv4, "src a kept from registers");
    report_test("forwarding", errs);
  endtask

  initial
  begin
    seed_ret      = $urandom(32'hd94d_2c23);
    err_count     = 0;
    check_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    stall_i       = 1'b0;
    flush_i       = 1'b0;
    valid_i       = 1'b0;
    opcode_i      = '0;
    operand_i     = '0;
    pc_i          = '0;
    wb_a_en_i     = 1'b0;
    wb_a_idx_i    = '0;
    wb_a_data_i   = '0;
    wb_b_en_i     = 1'b0;
    wb_b_idx_i    = '0;
    wb_b_data_i   = '0;
    ex_result_a_i = '0;
    ex_result_b_i = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    decode_table_test();
    reg_index_test();
    bubble_test();
    stall_test();
    reg_file_test();
    forwarding_test();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* moxie_decode_top.sv */
/* decode stage top: decoder, microcode ROM, register file and operand select
   writeback and execute-stage results arrive on plain ports */

`timescale 1ns/100ps

`include "moxie_consts.svh"

module moxie_decode_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       stall_i,
  input  logic                       flush_i,
  input  logic                       valid_i,
  input  logic [`MOXIE_INSN_W-1:0]   opcode_i,
  input  moxie_pkg::word_t           operand_i,
  input  moxie_pkg::word_t           pc_i,
  input  logic                       wb_a_en_i,
  input  moxie_pkg::reg_idx_t        wb_a_idx_i,
  input  moxie_pkg::word_t           wb_a_data_i,
  input  logic                       wb_b_en_i,
  input  moxie_pkg::reg_idx_t        wb_b_idx_i,
  input  moxie_pkg::word_t           wb_b_data_i,
  input  moxie_pkg::word_t           ex_result_a_i,
  input  moxie_pkg::word_t           ex_result_b_i,
  output moxie_pkg::op_e             op_o,
  output moxie_pkg::pcb_t            pcb_o,
  output moxie_pkg::reg_idx_t        wr_idx_a_o,
  output moxie_pkg::reg_idx_t        wr_idx_b_o,
  output moxie_pkg::word_t           operand_o,
  output logic [`MOXIE_OFFSET_W-1:0] offset_o,
  output moxie_pkg::word_t           pc_o,
  output moxie_pkg::word_t           src_a_o,
  output moxie_pkg::word_t           src_b_o
);

  moxie_pkg::pcb_t     rom_ctrl;
  moxie_pkg::reg_idx_t rd_idx_a;
  moxie_pkg::reg_idx_t rd_idx_b;
  moxie_pkg::word_t    rd_data_a;
  moxie_pkg::word_t    rd_data_b;

  decode_if dec_if ();

  microcode_rom microcode_rom_inst (
    .opcode_i (opcode_i[15:8]),
    .ctrl_o   (rom_ctrl)
  );

  instr_decoder instr_decoder_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .valid_i    (valid_i),
    .opcode_i   (opcode_i),
    .operand_i  (operand_i),
    .pc_i       (pc_i),
    .rom_ctrl_i (rom_ctrl),
    .rd_idx_a_o (rd_idx_a),
    .rd_idx_b_o (rd_idx_b),
    .dec        (dec_if.dec)
  );

  // reads advance with the decoder so data lines up with the decoded fields
  reg_file reg_file_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_en_i     (!stall_i),
    .rd_idx_a_i  (rd_idx_a),
    .rd_idx_b_i  (rd_idx_b),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .wr_en_a_i   (wb_a_en_i),
    .wr_idx_a_i  (wb_a_idx_i),
    .wr_data_a_i (wb_a_data_i),
    .wr_en_b_i   (wb_b_en_i),
    .wr_idx_b_i  (wb_b_idx_i),
    .wr_data_b_i (wb_b_data_i)
  );

  operand_fetch operand_fetch_inst (
    .opf           (dec_if.opf),
    .reg_a_i       (rd_data_a),
    .reg_b_i       (rd_data_b),
    .ex_result_a_i (ex_result_a_i),
    .ex_result_b_i (ex_result_b_i),
    .src_a_o       (src_a_o),
    .src_b_o       (src_b_o)
  );

  assign op_o       = dec_if.op;
  assign pcb_o      = dec_if.pcb;
  assign wr_idx_a_o = dec_if.wr_idx_a;
  assign wr_idx_b_o = dec_if.wr_idx_b;
  assign operand_o  = dec_if.operand;
  assign offset_o   = dec_if.pcrel_offset;
  assign pc_o       = dec_if.pc;

endmodule

/* operand_fetch.sv */
/* source operand select for the decoded instruction
   takes the execute-stage result when the instruction ahead writes the source,
   otherwise the value read from the register file */

`timescale 1ns/100ps

module operand_fetch (
  decode_if.opf            opf,
  input  moxie_pkg::word_t reg_a_i,
  input  moxie_pkg::word_t reg_b_i,
  input  moxie_pkg::word_t ex_result_a_i,
  input  moxie_pkg::word_t ex_result_b_i,
  output moxie_pkg::word_t src_a_o,
  output moxie_pkg::word_t src_b_o
);

  // result A has priority over result B
  function automatic moxie_pkg::word_t pick_src(
    input logic             fwd_from_a,
    input logic             fwd_from_b,
    input moxie_pkg::word_t reg_val
  );
    if (fwd_from_a)
      return ex_result_a_i;
    else if (fwd_from_b)
      return ex_result_b_i;
    else
      return reg_val;
  endfunction

  assign src_a_o = pick_src(opf.fwd_aa, opf.fwd_ba, reg_a_i);
  assign src_b_o = pick_src(opf.fwd_ab, opf.fwd_bb, reg_b_i);

  // two forwards into source A only make sense for one register
  always_comb
  begin
    assert (!(opf.fwd_aa && opf.fwd_ba) || (opf.wr_idx_a == opf.wr_idx_b))
      else $error("operand_fetch: forward from A and B into different registers");
  end

endmodule

/* reg_file.sv */
/* 16 x 32 general register file, two registered read ports and two write ports
   reads update only when rd_en_i is high so they stay aligned with decode */

`timescale 1ns/100ps

`include "moxie_consts.svh"

module reg_file (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rd_en_i,
  input  moxie_pkg::reg_idx_t rd_idx_a_i,
  input  moxie_pkg::reg_idx_t rd_idx_b_i,
  output moxie_pkg::word_t    rd_data_a_o,
  output moxie_pkg::word_t    rd_data_b_o,
  input  logic                wr_en_a_i,
  input  moxie_pkg::reg_idx_t wr_idx_a_i,
  input  moxie_pkg::word_t    wr_data_a_i,
  input  logic                wr_en_b_i,
  input  moxie_pkg::reg_idx_t wr_idx_b_i,
  input  moxie_pkg::word_t    wr_data_b_i
);

  moxie_pkg::word_t regs [`MOXIE_NREGS];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `MOXIE_NREGS; i++)
        regs[i] <= '0;
    end
    else
    begin
      if (wr_en_a_i)
        regs[wr_idx_a_i] <= wr_data_a_i;
      // port B comes last so it wins on a shared index
      if (wr_en_b_i)
        regs[wr_idx_b_i] <= wr_data_b_i;
    end
  end

  // reads see the contents from before this edge's writes
  always_ff @(posedge clk_i)
  begin
    if (rd_en_i)
    begin
      rd_data_a_o <= regs[rd_idx_a_i];
      rd_data_b_o <= regs[rd_idx_b_i];
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr_en_a_i && wr_en_b_i && (wr_idx_a_i == wr_idx_b_i)))
    else $warning("reg_file: both write ports target r%0d, port B kept", wr_idx_b_i);

endmodule

/* instr_decoder.sv */
/* registered decode of one 16-bit instruction per non-stalled cycle
   drives the decoded fields and forwarding flags onto a decode_if,
   and the register-file read indices combinationally */

`timescale 1ns/100ps

`include "moxie_consts.svh"

module instr_decoder (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     stall_i,
  input  logic                     flush_i,
  input  logic                     valid_i,
  input  logic [`MOXIE_INSN_W-1:0] opcode_i,
  input  moxie_pkg::word_t         operand_i,
  input  moxie_pkg::word_t         pc_i,
  input  moxie_pkg::pcb_t          rom_ctrl_i,
  output moxie_pkg::reg_idx_t      rd_idx_a_o,
  output moxie_pkg::reg_idx_t      rd_idx_b_o,
  decode_if.dec                    dec
);

  moxie_pkg::reg_idx_t ri_a;
  moxie_pkg::reg_idx_t ri_b;
  moxie_pkg::op_e      op_nxt;
  moxie_pkg::pcb_t     pcb_nxt;
  moxie_pkg::word_t    operand_nxt;

  // form 1 keeps A in bits 7:4, the other forms in 11:8
  assign ri_a = opcode_i[15] ? opcode_i[11:8] : opcode_i[7:4];
  assign ri_b = opcode_i[3:0];

  assign rd_idx_a_o = ri_a;
  assign rd_idx_b_o = ri_b;

  always_comb
  begin
    casez (opcode_i[15:8])
      8'h01: op_nxt = moxie_pkg::OP_LDI_L;
      8'h02: op_nxt = moxie_pkg::OP_MOV;
      8'h03: op_nxt = moxie_pkg::OP_JSRA;
      8'h04: op_nxt = moxie_pkg::OP_RET;
      8'h05: op_nxt = moxie_pkg::OP_ADD_L;
      8'h06: op_nxt = moxie_pkg::OP_PUSH;
      8'h07: op_nxt = moxie_pkg::OP_POP;
      8'h08: op_nxt = moxie_pkg::OP_LDA_L;
      8'h09: op_nxt = moxie_pkg::OP_STA_L;
      8'h0a: op_nxt = moxie_pkg::OP_LD_L;
      8'h0b: op_nxt = moxie_pkg::OP_ST_L;
      8'h0c: op_nxt = moxie_pkg::OP_LDO_L;
      8'h0d: op_nxt = moxie_pkg::OP_STO_L;
      8'h0e: op_nxt = moxie_pkg::OP_CMP;
      8'h0f: op_nxt = moxie_pkg::OP_NOP;
      8'h10: op_nxt = moxie_pkg::OP_SEX_B;
      8'h11: op_nxt = moxie_pkg::OP_SEX_S;
      8'h12: op_nxt = moxie_pkg::OP_ZEX_B;
      8'h13: op_nxt = moxie_pkg::OP_ZEX_S;
      8'h19: op_nxt = moxie_pkg::OP_JSR;
      8'h1a: op_nxt = moxie_pkg::OP_JMPA;
      8'h1b: op_nxt = moxie_pkg::OP_LDI_B;
      8'h1c: op_nxt = moxie_pkg::OP_LD_B;
      8'h1d: op_nxt = moxie_pkg::OP_LDA_B;
      8'h1e: op_nxt = moxie_pkg::OP_ST_B;
      8'h1f: op_nxt = moxie_pkg::OP_STA_B;
      8'h20: op_nxt = moxie_pkg::OP_LDI_S;
      8'h21: op_nxt = moxie_pkg::OP_LD_S;
      8'h22: op_nxt = moxie_pkg::OP_LDA_S;
      8'h23: op_nxt = moxie_pkg::OP_ST_S;
      8'h24: op_nxt = moxie_pkg::OP_STA_S;
      8'h25: op_nxt = moxie_pkg::OP_JMP;
      8'h26: op_nxt = moxie_pkg::OP_AND;
      8'h27: op_nxt = moxie_pkg::OP_LSHR;
      8'h28: op_nxt = moxie_pkg::OP_ASHL;
      8'h29: op_nxt = moxie_pkg::OP_SUB_L;
      8'h2a: op_nxt = moxie_pkg::OP_NEG;
      8'h2b: op_nxt = moxie_pkg::OP_OR;
      8'h2c: op_nxt = moxie_pkg::OP_NOT;
      8'h2d: op_nxt = moxie_pkg::OP_ASHR;
      8'h2e: op_nxt = moxie_pkg::OP_XOR;
      8'h2f: op_nxt = moxie_pkg::OP_MUL_L;
      8'h30: op_nxt = moxie_pkg::OP_SWI;
      8'h31: op_nxt = moxie_pkg::OP_DIV_L;
      8'h32: op_nxt = moxie_pkg::OP_UDIV_L;
      8'h33: op_nxt = moxie_pkg::OP_MOD_L;
      8'h34: op_nxt = moxie_pkg::OP_UMOD_L;
      8'h35: op_nxt = moxie_pkg::OP_BRK;
      8'h36: op_nxt = moxie_pkg::OP_LDO_B;
      8'h37: op_nxt = moxie_pkg::OP_STO_B;
      8'h38: op_nxt = moxie_pkg::OP_LDO_S;
      8'h39: op_nxt = moxie_pkg::OP_STO_S;
      // form 2
      8'b1000_????: op_nxt = moxie_pkg::OP_INC;
      8'b1001_????: op_nxt = moxie_pkg::OP_DEC;
      8'b1010_????: op_nxt = moxie_pkg::OP_GSR;
      8'b1011_????: op_nxt = moxie_pkg::OP_SSR;
      // form 3 branches, offset in bits 9:0
      8'b1100_00??: op_nxt = moxie_pkg::OP_BEQ;
      8'b1100_01??: op_nxt = moxie_pkg::OP_BNE;
      8'b1100_10??: op_nxt = moxie_pkg::OP_BLT;
      8'b1100_11??: op_nxt = moxie_pkg::OP_BGT;
      8'b1101_00??: op_nxt = moxie_pkg::OP_BLTU;
      8'b1101_01??: op_nxt = moxie_pkg::OP_BGTU;
      8'b1101_10??: op_nxt = moxie_pkg::OP_BGE;
      8'b1101_11??: op_nxt = moxie_pkg::OP_BLE;
      8'b1110_00??: op_nxt = moxie_pkg::OP_BGEU;
      8'b1110_01??: op_nxt = moxie_pkg::OP_BLEU;
      default:      op_nxt = moxie_pkg::OP_BAD;
    endcase
  end

  // operand only changes for forms that carry an immediate
  always_comb
  begin
    case (op_nxt)
      moxie_pkg::OP_LDI_L, moxie_pkg::OP_LDI_B, moxie_pkg::OP_LDI_S,
      moxie_pkg::OP_JSRA, moxie_pkg::OP_JMPA,
      moxie_pkg::OP_LDA_L, moxie_pkg::OP_LDA_B, moxie_pkg::OP_LDA_S,
      moxie_pkg::OP_STA_L, moxie_pkg::OP_STA_B, moxie_pkg::OP_STA_S:
        operand_nxt = operand_i;
      // offset stores keep the 16-bit displacement in the upper half
      moxie_pkg::OP_STO_L, moxie_pkg::OP_STO_B, moxie_pkg::OP_STO_S:
        operand_nxt = {{(`MOXIE_XLEN/2){1'b0}}, operand_i[`MOXIE_XLEN-1:`MOXIE_XLEN/2]};
      moxie_pkg::OP_INC, moxie_pkg::OP_DEC:
        operand_nxt = {{(`MOXIE_XLEN-8){1'b0}}, opcode_i[7:0]};
      default:
        operand_nxt = dec.operand;
    endcase
  end

  always_comb
  begin
    pcb_nxt = '0;
    if (!opcode_i[15])
      pcb_nxt = rom_ctrl_i;
    else if (op_nxt == moxie_pkg::OP_INC || op_nxt == moxie_pkg::OP_DEC)
      pcb_nxt.wa = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      dec.op     <= moxie_pkg::OP_NOP;
      dec.pcb    <= '0;
      dec.fwd_aa <= 1'b0;
      dec.fwd_ab <= 1'b0;
      dec.fwd_ba <= 1'b0;
      dec.fwd_bb <= 1'b0;
    end
    else if (!stall_i)
    begin
      // compare the instruction now on the outputs with the incoming sources
      dec.fwd_aa <= dec.pcb.wa && (dec.wr_idx_a == ri_a);
      dec.fwd_ab <= dec.pcb.wa && (dec.wr_idx_a == ri_b);
      dec.fwd_ba <= dec.pcb.wb && (dec.wr_idx_b == ri_a);
      dec.fwd_bb <= dec.pcb.wb && (dec.wr_idx_b == ri_b);
      if (flush_i || !valid_i)
      begin
        dec.op  <= moxie_pkg::OP_NOP;
        dec.pcb <= '0;
      end
      else
      begin
        dec.op  <= op_nxt;
        dec.pcb <= pcb_nxt;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      dec.pc <= pc_i;
      if (valid_i && !flush_i)
      begin
        dec.wr_idx_a     <= ri_a;
        dec.wr_idx_b     <= ri_b;
        dec.operand      <= operand_nxt;
        dec.pcrel_offset <= opcode_i[`MOXIE_OFFSET_W-1:0];
      end
    end
  end

  // a flush that is not stalled must leave a bubble behind
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (flush_i && !stall_i) |=> (dec.op == moxie_pkg::OP_NOP && dec.pcb == '0))
    else $error("instr_decoder: flush did not produce a NOP");

endmodule

/* microcode_rom.sv */
/* control-bit table for form-1 instructions, indexed by the opcode byte
   purely combinational, the decoder registers its output */

`timescale 1ns/100ps

`include "moxie_consts.svh"

module microcode_rom (
  input  logic [`MOXIE_OPC_BYTE_W-1:0] opcode_i,
  output moxie_pkg::pcb_t              ctrl_o
);

  always_comb
  begin
    ctrl_o = '0;
    case (opcode_i)
      // ldi, mov, add, extends and the alu group
      8'h01, 8'h02, 8'h05, 8'h10, 8'h11, 8'h12, 8'h13, 8'h1b, 8'h20,
      8'h26, 8'h27, 8'h28, 8'h29, 8'h2a, 8'h2b, 8'h2c, 8'h2d, 8'h2e,
      8'h2f, 8'h31, 8'h32, 8'h33, 8'h34:
        ctrl_o.wa = 1'b1;
      // loads: absolute, indirect and offset
      8'h08, 8'h0a, 8'h0c, 8'h1c, 8'h1d, 8'h21, 8'h22, 8'h36, 8'h38:
      begin
        ctrl_o.wa     = 1'b1;
        ctrl_o.mem_rd = 1'b1;
      end
      // stores
      8'h09, 8'h0b, 8'h0d, 8'h1e, 8'h1f, 8'h23, 8'h24, 8'h37, 8'h39:
        ctrl_o.mem_wr = 1'b1;
      // push updates the stack pointer in B
      8'h06:
      begin
        ctrl_o.wb     = 1'b1;
        ctrl_o.mem_wr = 1'b1;
      end
      // pop writes the value and the stack pointer
      8'h07:
      begin
        ctrl_o.wa     = 1'b1;
        ctrl_o.wb     = 1'b1;
        ctrl_o.mem_rd = 1'b1;
      end
      // jsra, ret, jsr, jmpa, jmp
      8'h03, 8'h04, 8'h19, 8'h1a, 8'h25:
        ctrl_o.ctrl_flow = 1'b1;
      // swi, brk
      8'h30, 8'h35:
        ctrl_o.sys = 1'b1;
      // cmp, nop and unassigned codes carry no control
      default:
        ctrl_o = '0;
    endcase
  end

  // every defined opcode byte must map to defined control bits
  always_comb
  begin
    assert ($isunknown(opcode_i) || !$isunknown(ctrl_o))
      else $error("microcode_rom: unknown control bits for opcode %h", opcode_i);
  end

endmodule

/* decode_if.sv */
/* decoded instruction as handed from the decoder to the operand stage
   the decoder drives through modport dec, the operand stage reads through opf */

`timescale 1ns/100ps

`include "moxie_consts.svh"

interface decode_if;

  moxie_pkg::op_e             op;
  moxie_pkg::pcb_t            pcb;
  moxie_pkg::reg_idx_t        wr_idx_a;
  moxie_pkg::reg_idx_t        wr_idx_b;
  moxie_pkg::word_t           operand;
  logic [`MOXIE_OFFSET_W-1:0] pcrel_offset;
  moxie_pkg::word_t           pc;

  // instruction one ahead writes our source: <writer port><reader port>
  logic fwd_aa;
  logic fwd_ab;
  logic fwd_ba;
  logic fwd_bb;

  modport dec (
    output op, pcb, wr_idx_a, wr_idx_b, operand, pcrel_offset, pc,
    output fwd_aa, fwd_ab, fwd_ba, fwd_bb
  );

  modport opf (
    input op, pcb, wr_idx_a, wr_idx_b, operand, pcrel_offset, pc,
    input fwd_aa, fwd_ab, fwd_ba, fwd_bb
  );

endinterface

/* moxie_pkg.sv */
/* types shared across the decode stage: operations, pipeline control bits,
   register indices and data words */

`include "moxie_consts.svh"

package moxie_pkg;

  // decoded operation, one value per instruction of the ISA
  typedef enum logic [`MOXIE_OP_W-1:0] {
    OP_NOP, OP_BAD,
    // form 1, register and long-immediate moves
    OP_LDI_L, OP_MOV, OP_JSRA, OP_RET, OP_ADD_L, OP_PUSH, OP_POP,
    OP_LDA_L, OP_STA_L, OP_LD_L, OP_ST_L, OP_LDO_L, OP_STO_L, OP_CMP,
    OP_SEX_B, OP_SEX_S, OP_ZEX_B, OP_ZEX_S,
    OP_JSR, OP_JMPA, OP_LDI_B, OP_LD_B, OP_LDA_B, OP_ST_B, OP_STA_B,
    OP_LDI_S, OP_LD_S, OP_LDA_S, OP_ST_S, OP_STA_S, OP_JMP,
    // form 1, alu group
    OP_AND, OP_LSHR, OP_ASHL, OP_SUB_L, OP_NEG, OP_OR, OP_NOT, OP_ASHR,
    OP_XOR, OP_MUL_L, OP_SWI, OP_DIV_L, OP_UDIV_L, OP_MOD_L, OP_UMOD_L,
    OP_BRK, OP_LDO_B, OP_STO_B, OP_LDO_S, OP_STO_S,
    // form 2
    OP_INC, OP_DEC, OP_GSR, OP_SSR,
    // form 3, conditional branches
    OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLTU, OP_BGTU,
    OP_BGE, OP_BLE, OP_BGEU, OP_BLEU
  } op_e;

  // pipeline control bits, msb first
  typedef struct packed {
    logic wa;
    logic wb;
    logic mem_rd;
    logic mem_wr;
    logic ctrl_flow;
    logic sys;
  } pcb_t;

  typedef logic [$clog2(`MOXIE_NREGS)-1:0] reg_idx_t;

  typedef logic [`MOXIE_XLEN-1:0] word_t;

endpackage

/* moxie_consts.svh */
/* widths shared by the decode stage, the register file and the package
   include wherever a data, index or opcode field width is needed */

`ifndef MOXIE_CONSTS_SVH
`define MOXIE_CONSTS_SVH

// data path and instruction widths
`define MOXIE_XLEN      32
`define MOXIE_INSN_W    16

// register file size
`define MOXIE_NREGS     16

// opcode fields
`define MOXIE_OPC_BYTE_W 8
`define MOXIE_OFFSET_W  10

// width of the decoded operation code
`define MOXIE_OP_W      7

`endif
